//--- rtl/l2_wr_cfg.svh
`ifndef L2_WR_CFG_SVH
`define L2_WR_CFG_SVH

// log2 of the words in one cache line. 1, 2 and 3 are supported.
`define L2_OFFSET_WIDTH 2

// words per cache line.
`define L2_LINE_WORDS (1 << `L2_OFFSET_WIDTH)

// byte address width on both the cache and memory sides.
`define L2_ADDR_W 32

`endif

//--- rtl/l2_wr_pkg.sv
`default_nettype none

`include "l2_wr_cfg.svh"

package l2_wr_pkg;

    // owner of the memory write channel, as seen by the arbiter.
    typedef enum logic [4:0] {
        IDLE   = 5'd0,
        DMA_AW = 5'd1,
        DMA_W  = 5'd2,
        DMA_B  = 5'd3,
        LINE   = 5'd4
    } wr_state_e;

    typedef struct packed {
        logic [`L2_ADDR_W-1:0] addr;
        logic [7:0]            len;  // beats minus one.
        logic [2:0]            size; // log2 of bytes per beat.
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [`L2_ADDR_W-1:0]              addr;
        logic [`L2_LINE_WORDS-1:0][31:0]    data; // word 0 goes out first.
    } line_req_t;

    typedef struct packed {
        logic [`L2_ADDR_W-1:0] addr;
        logic [31:0]           data;
        logic [3:0]            strb;
        logic [2:0]            size;
    } unc_req_t;

endpackage

`default_nettype wire

//--- rtl/l2_wr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module l2_wr_fsm (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   req,
    input  wire                   dma_sign,
    input  wire                   buf_busy,
    input  wire                   awready,
    input  wire                   wready,
    input  wire                   bvalid,
    output l2_wr_pkg::wr_state_e  crt
);

    l2_wr_pkg::wr_state_e state;
    l2_wr_pkg::wr_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            l2_wr_pkg::IDLE: begin
                if (req && dma_sign && !buf_busy) begin
                    state_nxt = l2_wr_pkg::DMA_AW; // a line in flight keeps the beat waiting.
                end
            end
            l2_wr_pkg::DMA_AW: begin
                if (awready) begin
                    state_nxt = l2_wr_pkg::DMA_W;
                end
            end
            l2_wr_pkg::DMA_W: begin
                if (wready) begin
                    state_nxt = l2_wr_pkg::DMA_B;
                end
            end
            l2_wr_pkg::DMA_B: begin
                if (bvalid) begin
                    state_nxt = l2_wr_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = l2_wr_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2_wr_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the buffer owns the channel for as long as it is busy.
    // An uncached write never starts then, so LINE only overrides IDLE.
    assign crt = (state == l2_wr_pkg::IDLE && buf_busy) ? l2_wr_pkg::LINE : state;

endmodule

`default_nettype wire

//--- rtl/wb_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_wr_cfg.svh"

module wb_beat_counter (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          clear,
    input  wire                          step,
    output logic [`L2_OFFSET_WIDTH-1:0]  beat,
    output logic                         last_beat
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat <= '0;
        end else if (clear) begin
            beat <= '0; // a new line always starts at word 0.
        end else if (step) begin
            beat <= beat + 1'b1; // wraps back to 0 after the last word.
        end
    end

    assign last_beat = (beat == `L2_OFFSET_WIDTH'(`L2_LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- rtl/line_write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_wr_cfg.svh"

module line_write_buffer (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    load,
    input  wire l2_wr_pkg::line_req_t line,
    output l2_wr_pkg::axi_aw_t     aw,
    output logic                   awvalid,
    input  wire                    awready,
    output l2_wr_pkg::axi_w_t      w,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire                    bvalid,
    output logic                   bready,
    output logic                   busy
);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_AW   = 2'd1;
    localparam logic [1:0] PH_W    = 2'd2;
    localparam logic [1:0] PH_B    = 2'd3;

    logic [1:0]                   phase;
    l2_wr_pkg::line_req_t         line_q;
    logic [`L2_OFFSET_WIDTH-1:0]  beat;
    logic                         last_beat;
    logic                         w_fire;

    assign w_fire = wvalid && wready;

    wb_beat_counter wb_beat_counter_inst (
        .clk       (clk),
        .rstn      (rstn),
        .clear     (load),
        .step      (w_fire),
        .beat      (beat),
        .last_beat (last_beat)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE: phase <= load ? PH_AW : PH_IDLE;
                PH_AW:   phase <= awready ? PH_W : PH_AW;
                PH_W:    phase <= (wready && last_beat) ? PH_B : PH_W;
                default: phase <= bvalid ? PH_IDLE : PH_B;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= line;
        end
    end

    always_comb begin
        aw.addr   = line_q.addr;
        aw.len    = 8'(`L2_LINE_WORDS - 1);
        aw.size   = 3'd2; // full 32-bit words.
        w.data    = line_q.data[beat];
        w.strb    = 4'hF;
        w.last    = last_beat;
    end

    assign awvalid = (phase == PH_AW);
    assign wvalid  = (phase == PH_W);
    assign bready  = (phase == PH_B);
    assign busy    = (phase != PH_IDLE);

endmodule

`default_nettype wire

//--- rtl/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire l2_wr_pkg::wr_state_e crt,
    input  wire                      req,
    input  wire                      dma_sign,
    input  wire l2_wr_pkg::line_req_t line,
    input  wire l2_wr_pkg::unc_req_t  unc,
    output logic                     addr_ok,
    output logic                     buf_load,
    output l2_wr_pkg::line_req_t     buf_line,
    input  wire l2_wr_pkg::axi_aw_t   buf_aw,
    input  wire                      buf_awvalid,
    output logic                     buf_awready,
    input  wire l2_wr_pkg::axi_w_t    buf_w,
    input  wire                      buf_wvalid,
    output logic                     buf_wready,
    output logic                     buf_bvalid,
    input  wire                      buf_bready,
    output l2_wr_pkg::axi_aw_t       aw,
    output logic                     awvalid,
    input  wire                      awready,
    output l2_wr_pkg::axi_w_t        w,
    output logic                     wvalid,
    input  wire                      wready,
    input  wire                      bvalid,
    output logic                     bready
);

    l2_wr_pkg::unc_req_t unc_q;
    logic                unc_start;

    // crt reads IDLE only while the buffer is free.
    assign unc_start = (crt == l2_wr_pkg::IDLE) && req && dma_sign;
    assign buf_load  = (crt == l2_wr_pkg::IDLE) && req && !dma_sign;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            unc_q <= '0;
        end else if (unc_start) begin
            unc_q <= unc; // held until the response comes back.
        end
    end

    always_comb begin
        addr_ok     = 1'b0;
        buf_line    = '0;
        buf_awready = 1'b0;
        buf_wready  = 1'b0;
        buf_bvalid  = 1'b0;
        aw          = '0;
        awvalid     = 1'b0;
        w           = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        case (crt)
            l2_wr_pkg::IDLE, l2_wr_pkg::LINE: begin
                addr_ok     = buf_load; // a line is acknowledged as it is taken.
                buf_line    = line;
                aw          = buf_aw;
                awvalid     = buf_awvalid;
                w           = buf_w;
                wvalid      = buf_wvalid;
                bready      = buf_bready;
                buf_awready = awready;
                buf_wready  = wready;
                buf_bvalid  = bvalid;
            end
            l2_wr_pkg::DMA_AW: begin
                aw.addr = unc_q.addr;
                aw.len  = 8'd0;
                aw.size = unc_q.size;
                awvalid = 1'b1;
            end
            l2_wr_pkg::DMA_W: begin
                w.data  = unc_q.data;
                w.strb  = unc_q.strb;
                w.last  = 1'b1;
                wvalid  = 1'b1;
                addr_ok = wready; // uncached beats are acknowledged on the data transfer.
            end
            l2_wr_pkg::DMA_B: begin
                bready = 1'b1;
            end
            default: begin
                bready = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/l2_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module l2_write_path (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      req,
    input  wire                      dma_sign,
    input  wire l2_wr_pkg::line_req_t line,
    input  wire l2_wr_pkg::unc_req_t  unc,
    output logic                     addr_ok,
    output l2_wr_pkg::axi_aw_t       aw,
    output logic                     awvalid,
    input  wire                      awready,
    output l2_wr_pkg::axi_w_t        w,
    output logic                     wvalid,
    input  wire                      wready,
    input  wire                      bvalid,
    output logic                     bready
);

    l2_wr_pkg::wr_state_e  crt;
    logic                  buf_busy;
    logic                  buf_load;
    l2_wr_pkg::line_req_t  buf_line;
    l2_wr_pkg::axi_aw_t    buf_aw;
    logic                  buf_awvalid;
    logic                  buf_awready;
    l2_wr_pkg::axi_w_t     buf_w;
    logic                  buf_wvalid;
    logic                  buf_wready;
    logic                  buf_bvalid;
    logic                  buf_bready;

    l2_wr_fsm l2_wr_fsm_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .dma_sign (dma_sign),
        .buf_busy (buf_busy),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .crt      (crt)
    );

    line_write_buffer line_write_buffer_inst (
        .clk     (clk),
        .rstn    (rstn),
        .load    (buf_load),
        .line    (buf_line),
        .aw      (buf_aw),
        .awvalid (buf_awvalid),
        .awready (buf_awready),
        .w       (buf_w),
        .wvalid  (buf_wvalid),
        .wready  (buf_wready),
        .bvalid  (buf_bvalid),
        .bready  (buf_bready),
        .busy    (buf_busy)
    );

    write_arbiter write_arbiter_inst (
        .clk         (clk),
        .rstn        (rstn),
        .crt         (crt),
        .req         (req),
        .dma_sign    (dma_sign),
        .line        (line),
        .unc         (unc),
        .addr_ok     (addr_ok),
        .buf_load    (buf_load),
        .buf_line    (buf_line),
        .buf_aw      (buf_aw),
        .buf_awvalid (buf_awvalid),
        .buf_awready (buf_awready),
        .buf_w       (buf_w),
        .buf_wvalid  (buf_wvalid),
        .buf_wready  (buf_wready),
        .buf_bvalid  (buf_bvalid),
        .buf_bready  (buf_bready),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

`default_nettype wire

//--- test/l2_write_path_assert.sv
`timescale 1ns/1ps
`default_nettype none

module l2_write_path_assert (
    input wire                     clk,
    input wire                     rstn,
    input wire l2_wr_pkg::axi_aw_t aw,
    input wire                     awvalid,
    input wire                     awready,
    input wire l2_wr_pkg::axi_w_t  w,
    input wire                     wvalid,
    input wire                     wready,
    input wire                     bvalid,
    input wire                     bready,
    input wire                     addr_ok
);

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw dropped or changed while awready was low");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w dropped or changed while wready was low");

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bready && !bvalid |=> bready)
        else $error("bready dropped before bvalid arrived");

    // the path stays quiet in the cycle that follows a reset edge.
    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !awvalid && !wvalid && !bready && !addr_ok)
        else $error("channel outputs active right after reset");

endmodule

`default_nettype wire

//--- test/l2_write_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_wr_cfg.svh"

module l2_write_path_tb;

    localparam int NUM_REQ    = 60;
    localparam int MAX_CYCLES = NUM_REQ * 40; // worst case per request with 3-cycle ready delays.

    logic                 clk;
    logic                 rstn;
    logic                 req;
    logic                 dma_sign;
    l2_wr_pkg::line_req_t line_req;
    l2_wr_pkg::unc_req_t  unc_req;
    logic                 addr_ok;
    l2_wr_pkg::axi_aw_t   aw;
    logic                 awvalid;
    logic                 awready = 1'b0;
    l2_wr_pkg::axi_w_t    w;
    logic                 wvalid;
    logic                 wready = 1'b0;
    logic                 bvalid = 1'b0;
    logic                 bready;

    logic [15:0]          lfsr_state = 16'd49901;
    logic                 nxt_dma;
    l2_wr_pkg::line_req_t nxt_line;
    l2_wr_pkg::unc_req_t  nxt_unc;
    l2_wr_pkg::axi_aw_t   exp_aw[$];
    l2_wr_pkg::axi_aw_t   got_aw[$];
    l2_wr_pkg::axi_w_t    exp_w[$];
    l2_wr_pkg::axi_w_t    got_w[$];
    l2_wr_pkg::axi_aw_t   aw_held;
    l2_wr_pkg::axi_w_t    w_held;
    logic                 aw_wait = 1'b0;
    logic                 w_wait = 1'b0;
    logic                 b_wait = 1'b0;
    logic                 rstn_q = 1'b1;
    logic                 primed = 1'b0;
    int                   req_count = 0;
    int                   resp_count = 0;
    int                   b_owed = 0; // responses the memory still has to send.
    int                   mismatch_errors = 0;
    int                   other_errors = 0;
    int                   cycle_count = 0;
    int                   aw_delay = 0;
    int                   w_delay = 0;
    int                   b_delay = 0;

    l2_write_path l2_write_path_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .dma_sign (dma_sign),
        .line     (line_req),
        .unc      (unc_req),
        .addr_ok  (addr_ok),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    bind l2_write_path l2_write_path_assert l2_write_path_assert_inst (
        .clk     (clk),
        .rstn    (rstn),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .addr_ok (addr_ok)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic make_request();
        int i;
        nxt_dma = 1'(rand_bits(1));
        if (nxt_dma) begin
            nxt_unc.addr = rand_bits(32) & 32'hFFFF_FFFC;
            nxt_unc.data = rand_bits(32);
            nxt_unc.strb = 4'(rand_bits(4));
            nxt_unc.size = 3'(rand_bits(2) % 3); // byte, half word or word.
        end else begin
            nxt_line.addr = rand_bits(32) & ~32'(`L2_LINE_WORDS * 4 - 1);
            for (i = 0; i < `L2_LINE_WORDS; i++) begin
                nxt_line.data[i] = rand_bits(32);
            end
        end
    endtask

    // expected beats come from the request that the cache holds at addr_ok.
    task automatic push_expected();
        l2_wr_pkg::axi_aw_t a;
        l2_wr_pkg::axi_w_t  b;
        int                 i;
        if (dma_sign) begin
            a.addr = unc_req.addr;
            a.len  = 8'd0;
            a.size = unc_req.size;
            exp_aw.push_back(a);
            b.data = unc_req.data;
            b.strb = unc_req.strb;
            b.last = 1'b1;
            exp_w.push_back(b);
        end else begin
            a.addr = line_req.addr;
            a.len  = 8'(`L2_LINE_WORDS - 1);
            a.size = 3'd2;
            exp_aw.push_back(a);
            for (i = 0; i < `L2_LINE_WORDS; i++) begin
                b.data = line_req.data[i];
                b.strb = 4'hF;
                b.last = (i == `L2_LINE_WORDS - 1);
                exp_w.push_back(b);
            end
        end
    endtask

    task automatic check_aw(input l2_wr_pkg::axi_aw_t got, input l2_wr_pkg::axi_aw_t want);
        if (got !== want) begin
            mismatch_errors++;
            $display("error at %0t: aw addr %h len %0d size %0d, expected %h %0d %0d",
                     $time, got.addr, got.len, got.size, want.addr, want.len, want.size);
        end
    endtask

    task automatic check_w(input l2_wr_pkg::axi_w_t got, input l2_wr_pkg::axi_w_t want);
        if (got !== want) begin
            mismatch_errors++;
            $display("error at %0t: w data %h strb %h last %b, expected %h %h %b",
                     $time, got.data, got.strb, got.last, want.data, want.strb, want.last);
        end
    endtask

    task automatic check_ctrl(input logic [3:0] got, input logic [3:0] want, input string what);
        if (got !== want) begin
            mismatch_errors++;
            $display("error at %0t: %s are %b, expected %b", $time, what, got, want);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // the memory slave answers each valid with a one-cycle ready pulse after 0 to 3 cycles.
    always @(negedge clk) begin
        if (awready) begin
            awready = 1'b0;
            aw_delay = int'(rand_bits(2));
        end else if (awvalid) begin
            if (aw_delay == 0) awready = 1'b1;
            else aw_delay--;
        end
        if (wready) begin
            wready = 1'b0;
            w_delay = int'(rand_bits(2));
        end else if (wvalid) begin
            if (w_delay == 0) wready = 1'b1;
            else w_delay--;
        end
        if (bvalid) begin
            bvalid = 1'b0;
            b_delay = int'(rand_bits(2));
        end else if (bready && b_owed > 0) begin
            if (b_delay == 0) bvalid = 1'b1;
            else b_delay--;
        end
    end

    always @(posedge clk) begin
        if (primed && (!rstn || !rstn_q)) begin
            check_ctrl({addr_ok, awvalid, wvalid, bready}, 4'b0000, "outputs around reset");
        end
        if (rstn) begin
            if (addr_ok) begin
                push_expected();
                req_count++;
                if (dma_sign && !(wvalid && wready)) begin
                    other_errors++;
                    $display("uncached addr_ok at %0t came without a W transfer", $time);
                end
            end
            if (aw_wait && (!awvalid || aw !== aw_held)) begin
                other_errors++;
                $display("aw was dropped or changed at %0t before awready", $time);
            end
            if (w_wait && (!wvalid || w !== w_held)) begin
                other_errors++;
                $display("w was dropped or changed at %0t before wready", $time);
            end
            if (b_wait && !bready) begin
                other_errors++;
                $display("bready fell at %0t before bvalid came", $time);
            end
            if (awvalid && awready) got_aw.push_back(aw);
            if (wvalid && wready) begin
                got_w.push_back(w);
                if (w.last) b_owed++;
            end
            if (bvalid && bready) begin
                resp_count++;
                b_owed--;
            end
            aw_wait = awvalid && !awready;
            aw_held = aw;
            w_wait = wvalid && !wready;
            w_held = w;
            b_wait = bready && !bvalid;
            while (exp_aw.size() > 0 && got_aw.size() > 0) begin
                check_aw(got_aw.pop_front(), exp_aw.pop_front());
            end
            while (exp_w.size() > 0 && got_w.size() > 0) begin
                check_w(got_w.pop_front(), exp_w.pop_front());
            end
        end
        primed = 1'b1;
        rstn_q = rstn;
    end

    initial begin
        int n;
        int gap;
        int end_errors;
        rstn = 1'b0;
        req = 1'b0;
        dma_sign = 1'b0;
        line_req = '0;
        unc_req = '0;
        nxt_line = '0;
        nxt_unc = '0;
        end_errors = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(posedge clk);
        for (n = 0; n < NUM_REQ; n++) begin
            make_request();
            @(negedge clk);
            req = 1'b1;
            dma_sign = nxt_dma;
            line_req = nxt_line;
            unc_req = nxt_unc;
            @(posedge clk);
            while (!addr_ok) @(posedge clk);
            gap = int'(rand_bits(2)); // zero keeps requests back to back.
            if (gap != 0) begin
                @(negedge clk);
                req = 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        @(negedge clk);
        req = 1'b0;
        while (resp_count < NUM_REQ) @(posedge clk);
        @(posedge clk);
        if (resp_count != req_count) begin
            end_errors++;
            $display("%0d requests were acknowledged but %0d responses came back",
                     req_count, resp_count);
        end
        if (exp_aw.size() + got_aw.size() + exp_w.size() + got_w.size() != 0) begin
            end_errors++;
            $display("transfers left unmatched: %0d/%0d aw and %0d/%0d w expected/seen",
                     exp_aw.size(), got_aw.size(), exp_w.size(), got_w.size());
        end
        $display("summary: %0d mismatches, %0d other errors", mismatch_errors,
                 other_errors + end_errors);
        if (mismatch_errors == 0 && other_errors == 0 && end_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- l2_write_path.f
+incdir+rtl
rtl/l2_wr_pkg.sv
rtl/l2_wr_fsm.sv
rtl/wb_beat_counter.sv
rtl/line_write_buffer.sv
rtl/write_arbiter.sv
rtl/l2_write_path.sv
test/l2_write_path_assert.sv
test/l2_write_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status 0 only on a passing run.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module l2_write_path_tb \
    -f l2_write_path.f -o l2_write_path_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/l2_write_path_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see $LOG"
fi

if grep -qxF ">>> PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
